// File: avmm_bridge.f
+incdir+include
hw/avmm_bridge_pkg.sv
hw/avmm_decode.sv
hw/avmm_reg_slave.sv
hw/avmm_bridge_top.sv
tb/tb_avmm_bridge.sv

// File: tb/tb_avmm_bridge.sv
/*
 Self-checking testbench for the Avalon-MM configuration fabric.
 Shadow banks model register aliasing of both address maps.
 Stops at the first error. Random stimulus comes from a fixed-seed LFSR.
*/
`timescale 1ns/1ps
`include "avmm_bridge_macros.svh"

module tb_avmm_bridge;

   import avmm_bridge_pkg::*;

   localparam int N_DIRECTED   = 160;    // Upper bound on directed transactions
   localparam int N_RANDOM     = 300;
   localparam int WATCHDOG_CYC = (N_DIRECTED + N_RANDOM) * 20 + 200;
   localparam int ACCEPT_LIMIT = 50;

   logic        avmm_clk = 1'b0;
   logic        avmm_rst_n;
   avmm_cmd_t   i_cmd;
   logic        i_user_mode;
   avmm_rsp_t   o_rsp;

   logic [15:0] lfsr_state;
   logic [31:0] pma_shadow  [1 << `PMA_IDX_W];
   logic [31:0] aib_shadow  [1 << `AIB_IDX_W];
   logic [31:0] ehip_shadow [1 << `EHIP_IDX_W];
   logic [31:0] exp_rdata  = '0;
   logic        rdval_due  = 1'b0;   // Read accepted on the previous edge

   avmm_bridge_top dut0 (
      .avmm_clk    (avmm_clk),
      .avmm_rst_n  (avmm_rst_n),
      .i_cmd       (i_cmd),
      .i_user_mode (i_user_mode),
      .o_rsp       (o_rsp)
   );

   always #5 avmm_clk = ~avmm_clk;

   // ----------------------------------------------------------------------
   // Random source and failure reporting
   // ----------------------------------------------------------------------
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v          = {v[30:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
      return v;
   endfunction

   task automatic stop_with_failure(input string msg);
      $display("%s", msg);
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         stop_with_failure($sformatf("MISMATCH time=%0t signal=%s got=%b expected=%b",
                                     $time, name, got, exp));
      end
   endtask

   task automatic check_rsp(input string name, input avmm_rsp_t got, input avmm_rsp_t exp);
      if (got !== exp) begin
         stop_with_failure($sformatf(
            "MISMATCH time=%0t signal=%s got=%h/%b/%b expected=%h/%b/%b", $time, name,
            got.rdata, got.rdatavalid, got.waitrequest,
            exp.rdata, exp.rdatavalid, exp.waitrequest));
      end
   endtask

   // ----------------------------------------------------------------------
   // Reference model
   // ----------------------------------------------------------------------
   function automatic target_e decode_region(input logic [16:0] addr, input logic mode);
      if (addr < `BASE_AIB) return tgt_pma;
      if (addr < `BASE_NAIB) return tgt_aib;
      if (mode) return (addr[7:6] == 2'b11) ? tgt_none : tgt_ehip;
      return (addr < `BASE_EHIP) ? tgt_none : tgt_ehip;
   endfunction

   // Local address reduced to the bank index, upper bits alias
   function automatic int region_index(input logic [16:0] addr, input logic mode,
                                       input target_e tgt);
      logic [16:0] loc;
      case (tgt)
         tgt_pma:  return int'(addr[6:0]) % (1 << `PMA_IDX_W);
         tgt_aib:  return int'(addr[5:0]) % (1 << `AIB_IDX_W);
         tgt_ehip: begin
            loc = mode ? {3'b000, addr[16:9], addr[5:0]} : addr - `BASE_EHIP;
            return int'(loc) % (1 << `EHIP_IDX_W);
         end
         default:  return 0;
      endcase
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wd,
                                               input logic [3:0] be);
      logic [31:0] r;
      r = old;
      for (int b = 0; b < 4; b++) begin
         if (be[b]) r[8*b +: 8] = wd[8*b +: 8];
      end
      return r;
   endfunction

   function automatic logic [31:0] shadow_read(input logic [16:0] addr, input logic mode);
      target_e tgt;
      int      i;
      tgt = decode_region(addr, mode);
      i   = region_index(addr, mode, tgt);
      case (tgt)
         tgt_pma:  return pma_shadow[i];
         tgt_aib:  return aib_shadow[i];
         tgt_ehip: return ehip_shadow[i];
         default:  return '0;            // Hole reads zero
      endcase
   endfunction

   function automatic void shadow_write(input avmm_cmd_t cmd, input logic mode);
      target_e tgt;
      int      i;
      tgt = decode_region(cmd.addr, mode);
      i   = region_index(cmd.addr, mode, tgt);
      case (tgt)
         tgt_pma:  pma_shadow[i]  = merge_bytes(pma_shadow[i], cmd.wdata, cmd.byte_en);
         tgt_aib:  aib_shadow[i]  = merge_bytes(aib_shadow[i], cmd.wdata, cmd.byte_en);
         tgt_ehip: ehip_shadow[i] = merge_bytes(ehip_shadow[i], cmd.wdata, cmd.byte_en);
         default:  ;                     // Hole writes dropped
      endcase
   endfunction

   // ----------------------------------------------------------------------
   // Response monitor and compare
   // ----------------------------------------------------------------------
   always @(posedge avmm_clk) begin
      avmm_rsp_t exp_rsp;
      if (avmm_rst_n) begin
         check_flag("o_rsp.rdatavalid", o_rsp.rdatavalid, rdval_due);
         if (rdval_due) begin
            exp_rsp.rdata       = exp_rdata;
            exp_rsp.rdatavalid  = 1'b1;
            exp_rsp.waitrequest = 1'b1;   // Waitrequest low for one cycle only
            check_rsp("o_rsp", o_rsp, exp_rsp);
         end
         rdval_due = 1'b0;
         if (!o_rsp.waitrequest) begin
            if (i_cmd.write) begin
               shadow_write(i_cmd, i_user_mode);
            end else if (i_cmd.read) begin
               exp_rdata = shadow_read(i_cmd.addr, i_user_mode);
               rdval_due = 1'b1;
            end else begin
               stop_with_failure("waitrequest dropped while no command was pending");
            end
         end
      end
   end

   // ----------------------------------------------------------------------
   // Master side stimulus
   // ----------------------------------------------------------------------
   task automatic issue_cmd(input avmm_cmd_t cmd, input logic mode);
      int waited;
      waited = 0;
      @(posedge avmm_clk);
      i_cmd       <= cmd;
      i_user_mode <= mode;
      @(posedge avmm_clk);
      while (o_rsp.waitrequest) begin
         waited++;
         if (waited > ACCEPT_LIMIT) begin
            stop_with_failure("command was never accepted, waitrequest stuck high");
         end
         @(posedge avmm_clk);
      end
      i_cmd <= '0;
   endtask

   task automatic drive_write(input logic [16:0] addr, input logic [31:0] data,
                              input logic [3:0] be, input logic mode);
      avmm_cmd_t cmd;
      cmd         = '0;
      cmd.write   = 1'b1;
      cmd.addr    = addr;
      cmd.wdata   = data;
      cmd.byte_en = be;
      issue_cmd(cmd, mode);
   endtask

   task automatic drive_read(input logic [16:0] addr, input logic mode);
      avmm_cmd_t cmd;
      cmd         = '0;
      cmd.read    = 1'b1;
      cmd.addr    = addr;
      cmd.byte_en = 4'hF;
      issue_cmd(cmd, mode);
   endtask

   // Every register of every bank through the configuration map
   task automatic sweep_read();
      for (int i = 0; i < (1 << `PMA_IDX_W); i++) drive_read(17'(i), 1'b0);
      for (int i = 0; i < (1 << `AIB_IDX_W); i++) drive_read(`BASE_AIB + 17'(i), 1'b0);
      for (int i = 0; i < (1 << `EHIP_IDX_W); i++) drive_read(`BASE_EHIP + 17'(i), 1'b0);
   endtask

   // ----------------------------------------------------------------------
   // Watchdog
   // ----------------------------------------------------------------------
   initial begin
      repeat (WATCHDOG_CYC) @(posedge avmm_clk);
      stop_with_failure("watchdog expired before the tests finished");
   end

   // ----------------------------------------------------------------------
   // Test sequence
   // ----------------------------------------------------------------------
   initial begin
      logic [16:0] addr;
      logic [31:0] data;
      logic [3:0]  be;
      logic        mode;
      avmm_rst_n  = 1'b0;
      i_cmd       = '0;
      i_user_mode = 1'b0;
      lfsr_state  = 16'd39160;
      foreach (pma_shadow[i]) pma_shadow[i] = '0;
      foreach (aib_shadow[i]) aib_shadow[i] = '0;
      foreach (ehip_shadow[i]) ehip_shadow[i] = '0;
      repeat (3) @(posedge avmm_clk);
      avmm_rst_n <= 1'b1;

      // Reset state and empty banks
      @(posedge avmm_clk);
      check_flag("o_rsp.waitrequest", o_rsp.waitrequest, 1'b1);
      check_flag("o_rsp.rdatavalid", o_rsp.rdatavalid, 1'b0);
      check_flag("slave strobes", dut0.pma_cmd.write | dut0.pma_cmd.read |
                 dut0.aib_cmd.write | dut0.aib_cmd.read |
                 dut0.ehip_cmd.write | dut0.ehip_cmd.read, 1'b0);
      sweep_read();

      // Partial byte enables per region
      drive_write(17'h005, 32'hA1B2_C3D4, 4'hF, 1'b0);
      drive_write(17'h005, 32'h5566_7788, 4'b0101, 1'b0);
      drive_read(17'h005, 1'b0);
      drive_write(17'h083, 32'h1122_3344, 4'hF, 1'b0);
      drive_write(17'h083, 32'hDEAD_BEEF, 4'b1010, 1'b0);
      drive_read(17'h083, 1'b0);
      drive_write(17'h10A, 32'h0F0F_0F0F, 4'hF, 1'b1);
      drive_write(17'h10A, 32'hCAFE_F00D, 4'b1100, 1'b0);
      drive_read(17'h10A, 1'b1);

      // Hole writes are dropped and hole reads return zero
      drive_write(17'h0C0, 32'hFFFF_FFFF, 4'hF, 1'b0);
      drive_write(17'h0FF, 32'h1234_5678, 4'hF, 1'b0);
      drive_write(17'h0C5, 32'h8765_4321, 4'hF, 1'b1);
      drive_write(17'h1D3, 32'hA5A5_A5A5, 4'hF, 1'b1);
      drive_read(17'h0C0, 1'b0);
      drive_read(17'h0FF, 1'b0);
      drive_read(17'h0C5, 1'b1);
      drive_read(17'h1D3, 1'b1);
      sweep_read();

      // Same address on both maps, and EHIP aliasing
      drive_write(17'h1C5, 32'h0BAD_CAFE, 4'hF, 1'b0);
      drive_read(17'h1C5, 1'b1);
      drive_read(17'h105, 1'b0);
      drive_read(17'h105, 1'b1);
      drive_write(17'h345, 32'h7E57_0001, 4'b0011, 1'b1);
      drive_read(17'h125, 1'b0);

      // Random mixed traffic
      for (int n = 0; n < N_RANDOM; n++) begin
         addr = {8'h00, 9'(rand_bits(9))};
         if (rand_bits(2) == 32'd3) addr[16:9] = 8'(rand_bits(8));
         mode = 1'(rand_bits(1));
         if (rand_bits(1) == 32'd1) begin
            data = rand_bits(32);
            be   = 4'(rand_bits(4));
            drive_write(addr, data, be, mode);
         end else begin
            drive_read(addr, mode);
         end
      end

      repeat (3) @(posedge avmm_clk);
      @(negedge avmm_clk);
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule : tb_avmm_bridge

// File: hw/avmm_bridge_top.sv
/*
 Configuration fabric top. One decoder routes master commands to the
 PMA, AIB and EHIP register banks. Bank sizes and timing come from the
 macro header.
*/
`timescale 1ns/1ps
`include "avmm_bridge_macros.svh"

module avmm_bridge_top (
   input  logic                      avmm_clk,
   input  logic                      avmm_rst_n,
   input  avmm_bridge_pkg::avmm_cmd_t i_cmd,
   input  logic                      i_user_mode,
   output avmm_bridge_pkg::avmm_rsp_t o_rsp
);

   import avmm_bridge_pkg::*;

   avmm_cmd_t pma_cmd;
   avmm_cmd_t aib_cmd;
   avmm_cmd_t ehip_cmd;
   avmm_rsp_t pma_rsp;
   avmm_rsp_t aib_rsp;
   avmm_rsp_t ehip_rsp;

   // ----------------------------------------------------------------------
   // Router
   // ----------------------------------------------------------------------
   avmm_decode u_decode (
      .avmm_clk    (avmm_clk),
      .avmm_rst_n  (avmm_rst_n),
      .i_cmd       (i_cmd),
      .i_user_mode (i_user_mode),
      .o_rsp       (o_rsp),
      .o_pma_cmd   (pma_cmd),
      .i_pma_rsp   (pma_rsp),
      .o_aib_cmd   (aib_cmd),
      .i_aib_rsp   (aib_rsp),
      .o_ehip_cmd  (ehip_cmd),
      .i_ehip_rsp  (ehip_rsp)
   );

   // ----------------------------------------------------------------------
   // Register-bank slaves
   // ----------------------------------------------------------------------
   avmm_reg_slave #(.IDX_W(`PMA_IDX_W), .WAIT_CYC(`PMA_WAIT), .RD_LAT(`PMA_RDLAT)) u_pma (
      .avmm_clk   (avmm_clk),
      .avmm_rst_n (avmm_rst_n),
      .i_cmd      (pma_cmd),
      .o_rsp      (pma_rsp)
   );

   avmm_reg_slave #(.IDX_W(`AIB_IDX_W), .WAIT_CYC(`AIB_WAIT), .RD_LAT(`AIB_RDLAT)) u_aib (
      .avmm_clk   (avmm_clk),
      .avmm_rst_n (avmm_rst_n),
      .i_cmd      (aib_cmd),
      .o_rsp      (aib_rsp)
   );

   avmm_reg_slave #(.IDX_W(`EHIP_IDX_W), .WAIT_CYC(`EHIP_WAIT), .RD_LAT(`EHIP_RDLAT)) u_ehip (
      .avmm_clk   (avmm_clk),
      .avmm_rst_n (avmm_rst_n),
      .i_cmd      (ehip_cmd),
      .o_rsp      (ehip_rsp)
   );

endmodule : avmm_bridge_top

// File: hw/avmm_reg_slave.sv
/*
 Register-bank Avalon-MM slave. Local address bits above IDX_W alias.
 Waitrequest stalls each request for WAIT_CYC cycles. Read data returns
 RD_LAT cycles after acceptance, RD_LAT must be at least 1.
 Assumes one outstanding transaction, as issued by the decoder.
*/
`timescale 1ns/1ps

module avmm_reg_slave #(
   parameter int IDX_W    = 4,
   parameter int WAIT_CYC = 0,
   parameter int RD_LAT   = 1
) (
   input  logic                      avmm_clk,
   input  logic                      avmm_rst_n,
   input  avmm_bridge_pkg::avmm_cmd_t i_cmd,
   output avmm_bridge_pkg::avmm_rsp_t o_rsp
);

   import avmm_bridge_pkg::*;

   localparam int NREG  = 2 ** IDX_W;
   localparam int CNT_W = (WAIT_CYC > 0) ? $clog2(WAIT_CYC + 1) : 1;

   logic [31:0]      regs [NREG];
   logic [IDX_W-1:0] idx;
   logic [CNT_W-1:0] stall_cnt;
   logic             req;
   logic             waitreq;
   logic             wr_accept;
   logic             rd_accept;
   logic [RD_LAT-1:0] rd_pipe;      // Read valid delay line
   logic [31:0]      rd_data;
   logic             rd_open;      // Accepted read still owes its valid pulse

   assign idx       = i_cmd.addr[IDX_W-1:0];
   assign req       = i_cmd.write | i_cmd.read;
   assign waitreq   = (stall_cnt != CNT_W'(WAIT_CYC));
   assign wr_accept = i_cmd.write & ~waitreq;
   assign rd_accept = i_cmd.read & ~waitreq;

   // ----------------------------------------------------------------------
   // Stall counter
   // ----------------------------------------------------------------------
   always_ff @(posedge avmm_clk or negedge avmm_rst_n) begin
      if (!avmm_rst_n) begin
         stall_cnt <= '0;
      end else if (!req || !waitreq) begin
         stall_cnt <= '0;              // Restart for the next request
      end else begin
         stall_cnt <= stall_cnt + 1'b1;
      end
   end

   // ----------------------------------------------------------------------
   // Register bank with byte enables
   // ----------------------------------------------------------------------
   always_ff @(posedge avmm_clk or negedge avmm_rst_n) begin
      if (!avmm_rst_n) begin
         for (int i = 0; i < NREG; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_accept) begin
         for (int b = 0; b < 4; b++) begin
            if (i_cmd.byte_en[b]) begin
               regs[idx][8*b +: 8] <= i_cmd.wdata[8*b +: 8];
            end
         end
      end
   end

   // ----------------------------------------------------------------------
   // Read return
   // ----------------------------------------------------------------------
   always_ff @(posedge avmm_clk or negedge avmm_rst_n) begin
      if (!avmm_rst_n) begin
         rd_pipe <= '0;
      end else begin
         rd_pipe <= (rd_pipe << 1) | RD_LAT'(rd_accept);
      end
   end

   // Sampled at acceptance, held until the valid pulse
   always_ff @(posedge avmm_clk) begin
      if (rd_accept) begin
         rd_data <= regs[idx];
      end
   end

   always_ff @(posedge avmm_clk or negedge avmm_rst_n) begin
      if (!avmm_rst_n) begin
         rd_open <= 1'b0;
      end else if (rd_accept) begin
         rd_open <= 1'b1;
      end else if (o_rsp.rdatavalid) begin
         rd_open <= 1'b0;              // Valid pulse delivered
      end
   end

   assign o_rsp.rdata       = rd_data;
   assign o_rsp.rdatavalid  = rd_pipe[RD_LAT-1];
   assign o_rsp.waitrequest = waitreq;

   a_rdval_after_read: assert property (@(posedge avmm_clk) disable iff (!avmm_rst_n)
      o_rsp.rdatavalid |-> rd_open)
      else $error("slave rdatavalid without an accepted read");

endmodule : avmm_reg_slave

// File: hw/avmm_decode.sv
/*
 Avalon-MM address decoder for PMA, AIB and EHIP register regions.
 Master must hold i_cmd and i_user_mode stable until waitrequest drops.
 Only one transaction is outstanding. Hole writes are dropped, hole reads
 return zero.
*/
`timescale 1ns/1ps
`include "avmm_bridge_macros.svh"

module avmm_decode (
   input  logic                      avmm_clk,
   input  logic                      avmm_rst_n,
   input  avmm_bridge_pkg::avmm_cmd_t i_cmd,
   input  logic                      i_user_mode,   // 1 selects the user address map
   output avmm_bridge_pkg::avmm_rsp_t o_rsp,
   output avmm_bridge_pkg::avmm_cmd_t o_pma_cmd,
   input  avmm_bridge_pkg::avmm_rsp_t i_pma_rsp,
   output avmm_bridge_pkg::avmm_cmd_t o_aib_cmd,
   input  avmm_bridge_pkg::avmm_rsp_t i_aib_rsp,
   output avmm_bridge_pkg::avmm_cmd_t o_ehip_cmd,
   input  avmm_bridge_pkg::avmm_rsp_t i_ehip_rsp
);

   import avmm_bridge_pkg::*;

   dec_state_e  state;
   dec_state_e  state_nxt;
   target_e     target;
   avmm_rsp_t   sel_rsp;         // Response of the decoded slave
   logic [16:0] ehip_cfg_addr;
   logic [16:0] ehip_addr;
   logic [31:0] rd_hold;         // Slave read data held until release
   logic [31:0] rsp_rdata;
   logic        rsp_rdatavalid;
   logic        rsp_waitreq;

   // Strobes come from the FSM, not from the master command
   function automatic avmm_cmd_t route_cmd(input avmm_cmd_t cmd, input logic hit,
                                           input dec_state_e st, input logic [16:0] laddr);
      avmm_cmd_t c;
      c       = cmd;
      c.addr  = laddr;
      c.write = hit && (st == st_write);
      c.read  = hit && (st == st_read);
      return c;
   endfunction

   // ----------------------------------------------------------------------
   // Command fan-out with region-local addresses
   // ----------------------------------------------------------------------
   assign ehip_cfg_addr = i_cmd.addr - `BASE_EHIP;
   assign ehip_addr     = i_user_mode ? {3'b000, i_cmd.addr[16:9], i_cmd.addr[5:0]}
                                      : ehip_cfg_addr;

   assign o_pma_cmd  = route_cmd(i_cmd, target == tgt_pma, state, {10'b0, i_cmd.addr[6:0]});
   assign o_aib_cmd  = route_cmd(i_cmd, target == tgt_aib, state, {11'b0, i_cmd.addr[5:0]});
   assign o_ehip_cmd = route_cmd(i_cmd, target == tgt_ehip, state, ehip_addr);

   always_comb begin
      case (target)
         tgt_pma:  sel_rsp = i_pma_rsp;
         tgt_aib:  sel_rsp = i_aib_rsp;
         tgt_ehip: sel_rsp = i_ehip_rsp;
         default:  sel_rsp = '{rdata: '0, rdatavalid: 1'b0, waitrequest: 1'b0}; // Hole never stalls
      endcase
   end

   // ----------------------------------------------------------------------
   // Transaction FSM
   // ----------------------------------------------------------------------
   always_comb begin
      state_nxt = state;
      case (state)
         st_idle: begin
            if (i_cmd.write) begin
               state_nxt = st_write;
            end else if (i_cmd.read) begin
               state_nxt = st_read;
            end
         end
         st_write: begin
            if (!sel_rsp.waitrequest) begin
               state_nxt = st_write_done;
            end
         end
         st_write_done: state_nxt = st_idle;
         st_read: begin
            if (target == tgt_none) begin
               state_nxt = st_release_waitreq;   // Nothing to wait for
            end else if (!sel_rsp.waitrequest) begin
               state_nxt = st_wait_rdval;
            end
         end
         st_wait_rdval: begin
            if (sel_rsp.rdatavalid) begin
               state_nxt = st_release_waitreq;
            end
         end
         st_release_waitreq: state_nxt = st_set_rdval;
         st_set_rdval:       state_nxt = st_idle;
         default:            state_nxt = st_idle;
      endcase
   end

   always_ff @(posedge avmm_clk or negedge avmm_rst_n) begin
      if (!avmm_rst_n) begin
         state          <= st_idle;
         target         <= tgt_none;
         rsp_waitreq    <= 1'b1;
         rsp_rdatavalid <= 1'b0;
      end else begin
         state <= state_nxt;
         if (state == st_idle) begin   // Decode once per transaction
            if (i_cmd.addr < `BASE_AIB) begin
               target <= tgt_pma;
            end else if (i_cmd.addr < `BASE_NAIB) begin
               target <= tgt_aib;
            end else if (!i_user_mode && (i_cmd.addr < `BASE_EHIP)) begin
               target <= tgt_none;
            end else if (i_user_mode && (i_cmd.addr[7:6] == 2'b11)) begin
               target <= tgt_none;
            end else begin
               target <= tgt_ehip;
            end
         end
         rsp_waitreq    <= !((state_nxt == st_write_done) || (state_nxt == st_release_waitreq));
         rsp_rdatavalid <= (state_nxt == st_set_rdval);
      end
   end

   // ----------------------------------------------------------------------
   // Read data merge
   // ----------------------------------------------------------------------
   always_ff @(posedge avmm_clk) begin
      if (state == st_idle) begin
         rd_hold <= '0;                  // Hole reads keep zero
      end else if ((state == st_wait_rdval) && sel_rsp.rdatavalid) begin
         rd_hold <= sel_rsp.rdata;
      end
      rsp_rdata <= (state_nxt == st_set_rdval) ? rd_hold : '0;
   end

   assign o_rsp.rdata       = rsp_rdata;
   assign o_rsp.rdatavalid  = rsp_rdatavalid;
   assign o_rsp.waitrequest = rsp_waitreq;

   // ----------------------------------------------------------------------
   // Checks
   // ----------------------------------------------------------------------
   a_target_held: assert property (@(posedge avmm_clk) disable iff (!avmm_rst_n)
      (state != st_idle) |=> $stable(target))
      else $error("decoder target changed during a transaction");

   // Valid pulse only in set_rdval, right after the one-cycle waitrequest release
   a_rdval_state: assert property (@(posedge avmm_clk) disable iff (!avmm_rst_n)
      o_rsp.rdatavalid |-> (state == st_set_rdval) && $past(!o_rsp.waitrequest))
      else $error("master rdatavalid outside set_rdval or without a waitrequest release");

   a_one_strobe: assert property (@(posedge avmm_clk) disable iff (!avmm_rst_n)
      $onehot0({o_pma_cmd.write, o_pma_cmd.read, o_aib_cmd.write, o_aib_cmd.read,
                o_ehip_cmd.write, o_ehip_cmd.read}))
      else $error("more than one slave strobe high");

endmodule : avmm_decode

// File: hw/avmm_bridge_pkg.sv
/*
 Shared types for the Avalon-MM configuration fabric.
 One transaction in flight at a time, single-word accesses only.
*/
package avmm_bridge_pkg;

   // ----------------------------------------------------------------------
   // Decoder transaction FSM
   // ----------------------------------------------------------------------
   typedef enum logic [2:0] {
      st_idle            = 3'h0,
      st_write           = 3'h1,
      st_write_done      = 3'h2,
      st_read            = 3'h3,
      st_wait_rdval      = 3'h4,
      st_release_waitreq = 3'h5,
      st_set_rdval       = 3'h6
   } dec_state_e;

   // Routed destination of a transaction
   typedef enum logic [1:0] {
      tgt_pma  = 2'h0,
      tgt_aib  = 2'h1,
      tgt_ehip = 2'h2,
      tgt_none = 2'h3   // Unmapped hole
   } target_e;

   // ----------------------------------------------------------------------
   // Bus bundles
   // ----------------------------------------------------------------------
   typedef struct packed {
      logic        write;
      logic        read;
      logic [16:0] addr;      // Word address, region-local on slave side
      logic [31:0] wdata;
      logic [3:0]  byte_en;
   } avmm_cmd_t;

   typedef struct packed {
      logic [31:0] rdata;
      logic        rdatavalid;
      logic        waitrequest;
   } avmm_rsp_t;

endpackage : avmm_bridge_pkg

// File: include/avmm_bridge_macros.svh
/*
 Address map bases are 17-bit word addresses on the master bus.
 Slave index widths set the bank depth. Upper local address bits alias.
 RDLAT values must be 1 or more. WAIT values may be 0.
*/
`ifndef AVMM_BRIDGE_MACROS_SVH
`define AVMM_BRIDGE_MACROS_SVH

// ----------------------------------------------------------------------
// Address map (word addresses)
// ----------------------------------------------------------------------
`define BASE_AIB     17'h080
`define BASE_NAIB    17'h0C0
`define BASE_EHIP    17'h100

// ----------------------------------------------------------------------
// Slave register banks
// ----------------------------------------------------------------------
`define PMA_IDX_W    4
`define AIB_IDX_W    3
`define EHIP_IDX_W   5

`define PMA_WAIT     0
`define AIB_WAIT     2
`define EHIP_WAIT    1

`define PMA_RDLAT    1
`define AIB_RDLAT    3
`define EHIP_RDLAT   2

`endif
